// ==== logic/klClk_defs.svh ====
/* Field widths, function select codes and the rate limit
   for the diagnostic clock-control block */
`ifndef KL_CLK_DEFS_SVH
`define KL_CLK_DEFS_SVH

// Field widths
`define KL_NIBBLE_W 4
`define KL_SEL_W 3
`define KL_DIAG_W 6
`define KL_BURST_W 8
`define KL_RATE_MAX 3   // Largest rate exponent, tick every 2^3 cycles

// Class 00x control functions
`define KL_FN_STOP 3'd0
`define KL_FN_START 3'd1
`define KL_FN_SSTEP 3'd2
`define KL_FN_BURST 3'd5
`define KL_FN_CLRRST 3'd6
`define KL_FN_SETRST 3'd7

// Class 04x load functions
`define KL_LD_BURSTLO 3'd2
`define KL_LD_BURSTHI 3'd3
`define KL_LD_SRCRATE 3'd4
`define KL_LD_DIS 3'd5
`define KL_LD_PARCHK 3'd6
`define KL_LD_MISC 3'd7

`endif

// ==== logic/klClkPkg.sv ====
/* Types shared by the clock-control modules: diagnostic command,
   load word views, function strobes, configuration and run status */
`default_nettype none
`include "klClk_defs.svh"

package klClkPkg;

  // One diagnostic command from the console side
  typedef struct packed {
    logic valid;
    logic isLoad;                       // 1 for class 04x
    logic [`KL_SEL_W-1:0] sel;
    logic [`KL_NIBBLE_W-1:0] data;
  } diagCmd_t;

  // Same data nibble, decoded differently by each load function
  typedef union packed {
    struct packed {
      logic [1:0] sourceSel;
      logic [1:0] rateSel;
    } srcRate;
    struct packed {
      logic unused;
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } dis;
    struct packed {
      logic fm;
      logic cram;
      logic dram;
      logic fs;
    } parChk;
    struct packed {
      logic mboxCycleDis;
      logic respSim;
      logic arParCheck;
      logic errStopEn;
    } misc;
  } loadWord_t;

  // One-cycle function strobes, at most one high
  typedef struct packed {
    logic stop;
    logic start;
    logic singleStep;
    logic burst;
    logic clrReset;
    logic setReset;
    logic ldBurstLo;
    logic ldBurstHi;
    logic ldSrcRate;
    logic ldDis;
    logic ldParChk;
    logic ldMisc;
  } funcStrobes_t;

  typedef struct packed {
    logic [1:0] sourceSel;              // Stored for readback only
    logic [1:0] rateSel;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
    logic fmParChk;
    logic cramParChk;
    logic dramParChk;
    logic fsParChk;
    logic mboxCycleDis;
    logic respSim;
    logic arParCheck;
    logic errStopEn;
  } clkConfig_t;

  typedef struct packed {
    logic go;
    logic burstMode;
    logic stepPending;
    logic eboxReset;
    logic burstZero;
  } runStatus_t;

endpackage

`default_nettype wire

// ==== logic/clkFuncDecode.sv ====
/* Diagnostic function decoder that registers each command
   into one-cycle function strobes plus the load word */
`timescale 1ns/1ps
`default_nettype none
`include "klClk_defs.svh"

module clkFuncDecode (
  input  wire logic                  CLK,
  input  wire logic                  FPGA_RESET,
  input  wire klClkPkg::diagCmd_t    cmd,
  output klClkPkg::funcStrobes_t     strobes,
  output klClkPkg::loadWord_t        loadData
);

  klClkPkg::funcStrobes_t strobesNext;

  always_comb begin
    strobesNext = '0;
    if (cmd.valid) begin
      if (!cmd.isLoad) begin              // Class 00x
        case (cmd.sel)
          `KL_FN_STOP:   strobesNext.stop = 1'b1;
          `KL_FN_START:  strobesNext.start = 1'b1;
          `KL_FN_SSTEP:  strobesNext.singleStep = 1'b1;
          `KL_FN_BURST:  strobesNext.burst = 1'b1;
          `KL_FN_CLRRST: strobesNext.clrReset = 1'b1;
          `KL_FN_SETRST: strobesNext.setReset = 1'b1;
          default:       strobesNext = '0;  // Selects 3 and 4 unused here
        endcase
      end else begin                      // Class 04x
        case (cmd.sel)
          `KL_LD_BURSTLO: strobesNext.ldBurstLo = 1'b1;
          `KL_LD_BURSTHI: strobesNext.ldBurstHi = 1'b1;
          `KL_LD_SRCRATE: strobesNext.ldSrcRate = 1'b1;
          `KL_LD_DIS:     strobesNext.ldDis = 1'b1;
          `KL_LD_PARCHK:  strobesNext.ldParChk = 1'b1;
          `KL_LD_MISC:    strobesNext.ldMisc = 1'b1;
          default:        strobesNext = '0;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      strobes <= '0;
    end else begin
      strobes <= strobesNext;
    end
  end

  // Nibble rides alongside its strobe
  always_ff @(posedge CLK) begin
    loadData <= cmd.data;
  end

endmodule

`default_nettype wire

// ==== logic/clkConfigRegs.sv ====
/* Configuration registers for the source/rate, board disable,
   parity-check and miscellaneous load functions */
`timescale 1ns/1ps
`default_nettype none

module clkConfigRegs (
  input  wire logic                   CLK,
  input  wire logic                   FPGA_RESET,
  input  wire klClkPkg::funcStrobes_t strobes,
  input  wire klClkPkg::loadWord_t    loadData,
  output klClkPkg::clkConfig_t        cfg
);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      cfg <= '0;                          // Rate 0, every board enabled
    end else begin
      if (strobes.ldSrcRate) begin
        cfg.sourceSel <= loadData.srcRate.sourceSel;
        cfg.rateSel   <= loadData.srcRate.rateSel;
      end
      // Top bit of this word has no meaning
      if (strobes.ldDis) begin
        cfg.crmDis <= loadData.dis.crmDis;
        cfg.edpDis <= loadData.dis.edpDis;
        cfg.ctlDis <= loadData.dis.ctlDis;
      end
      if (strobes.ldParChk) begin
        cfg.fmParChk   <= loadData.parChk.fm;
        cfg.cramParChk <= loadData.parChk.cram;
        cfg.dramParChk <= loadData.parChk.dram;
        cfg.fsParChk   <= loadData.parChk.fs;
      end
      if (strobes.ldMisc) begin
        cfg.mboxCycleDis <= loadData.misc.mboxCycleDis;
        cfg.respSim      <= loadData.misc.respSim;
        cfg.arParCheck   <= loadData.misc.arParCheck;
        cfg.errStopEn    <= loadData.misc.errStopEn;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/clkBurstCounter.sv ====
/* 8-bit burst down-counter, loaded one nibble at a time,
   with its zero flag */
`timescale 1ns/1ps
`default_nettype none
`include "klClk_defs.svh"

module clkBurstCounter (
  input  wire logic                   CLK,
  input  wire logic                   FPGA_RESET,
  input  wire klClkPkg::funcStrobes_t strobes,
  input  wire klClkPkg::loadWord_t    loadData,
  input  wire logic                   burstDec,
  output logic [`KL_BURST_W-1:0]      count,
  output logic                        burstZero
);

  localparam int NibW = `KL_NIBBLE_W;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      count <= '0;
    end else if (strobes.ldBurstLo) begin
      count[NibW-1:0] <= loadData;        // Low nibble
    end else if (strobes.ldBurstHi) begin
      count[`KL_BURST_W-1:NibW] <= loadData;
    end else if (burstDec) begin
      count <= count - 1'b1;              // One EBOX clock spent
    end
  end

  assign burstZero = (count == '0);

  // Run control must stop issuing pulses once the count runs out
  aNoDecAtZero: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    burstDec |-> !burstZero)
    else $error("burst decrement with counter at zero");

endmodule

`default_nettype wire

// ==== logic/clkRunControl.sv ====
/* Run mode FSM, rate divider, EBOX reset flag and the
   per-board clock enables */
`timescale 1ns/1ps
`default_nettype none
`include "klClk_defs.svh"

module clkRunControl (
  input  wire logic                   CLK,
  input  wire logic                   FPGA_RESET,
  input  wire klClkPkg::funcStrobes_t strobes,
  input  wire klClkPkg::clkConfig_t   cfg,
  input  wire logic                   burstZero,
  output logic                        burstDec,
  output logic                        eboxClkEn,
  output logic                        crmClkEn,
  output logic                        edpClkEn,
  output logic                        ctlClkEn,
  output logic                        eboxReset,
  output klClkPkg::runStatus_t        status
);

  localparam int DivW = `KL_RATE_MAX;     // Divider reaches 2^max - 1

  logic            go;
  logic            burstMode;
  logic            stepPending;
  logic [DivW-1:0] divCnt;
  logic [DivW-1:0] divLast;
  logic            tick;
  logic            modeSet;

  assign modeSet = strobes.start | strobes.burst | strobes.singleStep;
  assign divLast = DivW'((1 << cfg.rateSel) - 1);
  assign tick    = (divCnt == divLast);

  // Divider restarts with every new mode so the first tick is a full period out
  always_ff @(posedge CLK) begin
    if (FPGA_RESET || modeSet) begin
      divCnt <= '0;
    end else if (tick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET || strobes.stop) begin
      go          <= 1'b0;
      burstMode   <= 1'b0;
      stepPending <= 1'b0;
    end else if (modeSet) begin
      go          <= strobes.start;
      burstMode   <= strobes.burst;
      stepPending <= strobes.singleStep;
    end else begin
      if (burstMode && burstZero) burstMode <= 1'b0;   // Burst ran out
      if (stepPending && tick) stepPending <= 1'b0;    // Step taken
    end
  end

  // EBOX comes out of reset held
  always_ff @(posedge CLK) begin
    if (FPGA_RESET || strobes.setReset) begin
      eboxReset <= 1'b1;
    end else if (strobes.clrReset) begin
      eboxReset <= 1'b0;
    end
  end

  assign burstDec  = tick & burstMode & ~burstZero;
  assign eboxClkEn = tick & (go | stepPending) | burstDec;

  assign crmClkEn = eboxClkEn & ~cfg.crmDis;
  assign edpClkEn = eboxClkEn & ~cfg.edpDis;
  assign ctlClkEn = eboxClkEn & ~cfg.ctlDis;

  assign status = '{go: go, burstMode: burstMode, stepPending: stepPending,
                    eboxReset: eboxReset, burstZero: burstZero};

  aOneMode: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    $onehot0({go, burstMode, stepPending}))
    else $error("more than one run mode active");

endmodule

`default_nettype wire

// ==== logic/clkDiagRead.sv ====
/* Diagnostic readback: selects one 6-bit word of counter,
   run status or configuration and registers it */
`timescale 1ns/1ps
`default_nettype none
`include "klClk_defs.svh"

module clkDiagRead (
  input  wire logic                  CLK,
  input  wire logic                  FPGA_RESET,
  input  wire logic                  rdEn,
  input  wire logic [`KL_SEL_W-1:0]  rdSel,
  input  wire klClkPkg::clkConfig_t  cfg,
  input  wire logic [`KL_BURST_W-1:0] count,
  input  wire klClkPkg::runStatus_t  status,
  output logic                       rdValid,
  output logic [`KL_DIAG_W-1:0]      rdData
);

  logic [`KL_DIAG_W-1:0] rdWord;

  always_comb begin
    case (rdSel)
      3'd0: rdWord = count[7:2];
      3'd1: rdWord = {count[1:0], status.go, status.burstMode,
                      status.stepPending, status.eboxReset};
      3'd2: rdWord = {cfg.sourceSel, cfg.rateSel, cfg.crmDis, cfg.edpDis};
      3'd3: rdWord = {cfg.ctlDis, cfg.fmParChk, cfg.cramParChk,
                      cfg.dramParChk, cfg.fsParChk, cfg.mboxCycleDis};
      3'd4: rdWord = {cfg.respSim, cfg.arParCheck, cfg.errStopEn,
                      status.burstZero, 2'b00};
      default: rdWord = '0;               // Unassigned selects
    endcase
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rdEn;                    // Answer every request
    end
  end

  // Data only meaningful with rdValid
  always_ff @(posedge CLK) begin
    if (rdEn) begin
      rdData <= rdWord;
    end
  end

endmodule

`default_nettype wire

// ==== logic/klClk.sv ====
/* Top level of the diagnostic clock-control block:
   decoder, config, burst counter, run control and readback */
`timescale 1ns/1ps
`default_nettype none
`include "klClk_defs.svh"

module klClk (
  input  wire logic                  CLK,
  input  wire logic                  FPGA_RESET,
  input  wire klClkPkg::diagCmd_t    cmd,
  input  wire logic                  rdEn,
  input  wire logic [`KL_SEL_W-1:0]  rdSel,
  output logic                       eboxClkEn,
  output logic                       crmClkEn,
  output logic                       edpClkEn,
  output logic                       ctlClkEn,
  output logic                       eboxReset,
  output logic                       rdValid,
  output logic [`KL_DIAG_W-1:0]      rdData
);

  klClkPkg::funcStrobes_t  strobes;
  klClkPkg::loadWord_t     loadData;
  klClkPkg::clkConfig_t    cfg;
  klClkPkg::runStatus_t    status;
  logic [`KL_BURST_W-1:0]  count;
  logic                    burstZero;
  logic                    burstDec;     // Run control back to counter

  clkFuncDecode u_funcDecode (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .cmd        (cmd),
    .strobes    (strobes),
    .loadData   (loadData)
  );

  clkConfigRegs u_configRegs (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .strobes    (strobes),
    .loadData   (loadData),
    .cfg        (cfg)
  );

  clkBurstCounter u_burstCounter (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .strobes    (strobes),
    .loadData   (loadData),
    .burstDec   (burstDec),
    .count      (count),
    .burstZero  (burstZero)
  );

  clkRunControl u_runControl (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .strobes    (strobes),
    .cfg        (cfg),
    .burstZero  (burstZero),
    .burstDec   (burstDec),
    .eboxClkEn  (eboxClkEn),
    .crmClkEn   (crmClkEn),
    .edpClkEn   (edpClkEn),
    .ctlClkEn   (ctlClkEn),
    .eboxReset  (eboxReset),
    .status     (status)
  );

  clkDiagRead u_diagRead (
    .CLK        (CLK),
    .FPGA_RESET (FPGA_RESET),
    .rdEn       (rdEn),
    .rdSel      (rdSel),
    .cfg        (cfg),
    .count      (count),
    .status     (status),
    .rdValid    (rdValid),
    .rdData     (rdData)
  );

endmodule

`default_nettype wire

// ==== tests/klClkTb.sv ====
/* Table-driven testbench for the clock-control block with a
   reference model, LFSR stimulus, checks and timeout */
`timescale 1ns/1ps
`default_nettype none
`include "klClk_defs.svh"

module klClkTb;

  localparam logic [1:0] OpCmd = 2'd0;
  localparam logic [1:0] OpRead = 2'd1;
  localparam logic [1:0] OpPulse = 2'd2;

  typedef struct packed {
    logic [1:0] op;
    logic       isLoad;
    logic [2:0] sel;                      // Function select or readback select
    logic [3:0] data;
    logic       rnd;                      // Take data from the LFSR
    logic [7:0] expPulses;
    logic [7:0] window;
  } row_t;

  logic CLK = 1'b0;
  logic FPGA_RESET = 1'b1;
  klClkPkg::diagCmd_t cmd = '0;
  logic rdEn = 1'b0;
  logic [`KL_SEL_W-1:0] rdSel = '0;
  logic eboxClkEn, crmClkEn, edpClkEn, ctlClkEn, eboxReset, rdValid;
  logic [`KL_DIAG_W-1:0] rdData;

  row_t rows[$];
  logic [31:0] lfsr = 32'd83399;
  int cycles = 0;
  int limit = 1000;

  // Reference model state
  klClkPkg::clkConfig_t mCfg = '0;
  logic [7:0] mCount = '0;
  logic mGo = 1'b0, mBurst = 1'b0, mStep = 1'b0, mReset = 1'b1;

  klClk u_klClk (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .cmd(cmd), .rdEn(rdEn), .rdSel(rdSel),
    .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn),
    .ctlClkEn(ctlClkEn), .eboxReset(eboxReset), .rdValid(rdValid), .rdData(rdData)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Run did not finish within %0d cycles", limit);
      $display("test failed");
      $fatal(1);
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randNibble(output logic [3:0] n);
    for (int i = 0; i < 4; i++) begin
      lfsr = lfsrStep(lfsr);
      n[i] = lfsr[0];
    end
  endtask

  task automatic addRow(input logic [1:0] op, input logic isLoad, input logic [2:0] sel,
                        input logic [3:0] data, input logic rnd,
                        input logic [7:0] expPulses, input logic [7:0] window);
    rows.push_back('{op, isLoad, sel, data, rnd, expPulses, window});
  endtask

  task automatic checkVal(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic nextCycle();
    @(posedge CLK);
    #1;
  endtask

  // Model of one decoded command
  task automatic modelCmd(input logic isLoad, input logic [2:0] sel, input logic [3:0] d);
    if (!isLoad) begin
      case (sel)
        `KL_FN_STOP:   {mGo, mBurst, mStep} = 3'b000;
        `KL_FN_START:  {mGo, mBurst, mStep} = 3'b100;
        `KL_FN_SSTEP:  {mGo, mBurst, mStep} = 3'b001;
        `KL_FN_BURST:  {mGo, mBurst, mStep} = 3'b010;
        `KL_FN_CLRRST: mReset = 1'b0;
        `KL_FN_SETRST: mReset = 1'b1;
        default: ;
      endcase
    end else begin
      case (sel)
        `KL_LD_BURSTLO: mCount[3:0] = d;
        `KL_LD_BURSTHI: mCount[7:4] = d;
        `KL_LD_SRCRATE: {mCfg.sourceSel, mCfg.rateSel} = d;
        `KL_LD_DIS:     {mCfg.crmDis, mCfg.edpDis, mCfg.ctlDis} = d[2:0];
        `KL_LD_PARCHK:
          {mCfg.fmParChk, mCfg.cramParChk, mCfg.dramParChk, mCfg.fsParChk} = d;
        `KL_LD_MISC:
          {mCfg.mboxCycleDis, mCfg.respSim, mCfg.arParCheck, mCfg.errStopEn} = d;
        default: ;
      endcase
    end
  endtask

  function automatic logic [5:0] expWord(input logic [2:0] sel);
    case (sel)
      3'd0: return mCount[7:2];
      3'd1: return {mCount[1:0], mGo, mBurst, mStep, mReset};
      3'd2: return {mCfg.sourceSel, mCfg.rateSel, mCfg.crmDis, mCfg.edpDis};
      3'd3: return {mCfg.ctlDis, mCfg.fmParChk, mCfg.cramParChk, mCfg.dramParChk,
                    mCfg.fsParChk, mCfg.mboxCycleDis};
      3'd4: return {mCfg.respSim, mCfg.arParCheck, mCfg.errStopEn,
                    mCount == 8'd0, 2'b00};
      default: return 6'd0;
    endcase
  endfunction

  task automatic runCmd(input row_t r);
    logic [3:0] d;
    d = r.data;
    if (r.rnd) randNibble(d);
    cmd = '{valid: 1'b1, isLoad: r.isLoad, sel: r.sel, data: d};
    nextCycle();
    cmd = '0;
    modelCmd(r.isLoad, r.sel, d);
  endtask

  task automatic runRead(input row_t r);
    nextCycle();                          // Let the last load settle
    rdEn = 1'b1;
    rdSel = r.sel;
    nextCycle();
    rdEn = 1'b0;
    checkVal("rdValid", 8'(rdValid), 8'd1);
    checkVal($sformatf("rdData sel %0d", r.sel), 8'(rdData), 8'(expWord(r.sel)));
    checkVal("eboxReset", 8'(eboxReset), 8'(mReset));
  endtask

  // Count enable pulses from the cycle after the strobe
  task automatic runPulses(input row_t r);
    int period;
    int seen;
    int m;
    logic exp;
    period = 1 << mCfg.rateSel;
    seen = 0;
    for (int j = 1; j <= int'(r.window); j++) begin
      nextCycle();
      m = j / period;
      exp = (j % period == 0) &&
            (mGo || (mBurst && m <= int'(mCount)) || (mStep && m == 1));
      checkVal("eboxClkEn", 8'(eboxClkEn), 8'(exp));
      checkVal("crmClkEn", 8'(crmClkEn), 8'(exp & ~mCfg.crmDis));
      checkVal("edpClkEn", 8'(edpClkEn), 8'(exp & ~mCfg.edpDis));
      checkVal("ctlClkEn", 8'(ctlClkEn), 8'(exp & ~mCfg.ctlDis));
      checkVal("rdValid", 8'(rdValid), 8'd0);   // No read pending here
      if (eboxClkEn) seen++;
    end
    checkVal("pulse count", 8'(seen), r.expPulses);
    if (mBurst) begin
      mCount = mCount - 8'(seen);
      if (mCount == 0) mBurst = 1'b0;
    end
    if (mStep && seen > 0) mStep = 1'b0;
  endtask

  initial begin
    // Reset state, then EBOX reset flag
    addRow(OpPulse, 0, 0, 0, 0, 0, 4);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_CLRRST, 0, 0, 0, 0);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_SETRST, 0, 0, 0, 0);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    addRow(OpCmd, 0, 3'd3, 0, 0, 0, 0);   // No function
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    // Random configuration loads
    addRow(OpCmd, 1, `KL_LD_SRCRATE, 0, 1, 0, 0);
    addRow(OpRead, 0, 2, 0, 0, 0, 0);
    addRow(OpRead, 0, 3, 0, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_DIS, 0, 1, 0, 0);
    addRow(OpRead, 0, 2, 0, 0, 0, 0);
    addRow(OpRead, 0, 3, 0, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_PARCHK, 0, 1, 0, 0);
    addRow(OpRead, 0, 3, 0, 0, 0, 0);
    addRow(OpRead, 0, 2, 0, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_MISC, 0, 1, 0, 0);
    addRow(OpRead, 0, 3, 0, 0, 0, 0);
    addRow(OpRead, 0, 4, 0, 0, 0, 0);
    // Burst counter nibbles
    addRow(OpCmd, 1, `KL_LD_BURSTLO, 0, 1, 0, 0);
    addRow(OpCmd, 1, `KL_LD_BURSTHI, 0, 1, 0, 0);
    addRow(OpRead, 0, 0, 0, 0, 0, 0);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    // Burst of 5 at rate 1, then 3 at rate 2
    addRow(OpCmd, 1, `KL_LD_SRCRATE, 4'b0001, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_DIS, 4'b0000, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_BURSTLO, 4'd5, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_BURSTHI, 4'd0, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_BURST, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 5, 14);
    addRow(OpRead, 0, 4, 0, 0, 0, 0);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_SRCRATE, 4'b1110, 0, 0, 0);
    addRow(OpCmd, 1, `KL_LD_BURSTLO, 4'd3, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_BURST, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 3, 16);
    addRow(OpRead, 0, 4, 0, 0, 0, 0);
    // Single step, then start and stop
    addRow(OpCmd, 1, `KL_LD_SRCRATE, 4'b0001, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_SSTEP, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 1, 6);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_START, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 6, 12);
    addRow(OpCmd, 0, `KL_FN_STOP, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 0, 8);
    addRow(OpRead, 0, 1, 0, 0, 0, 0);
    // CRM board disabled during free run
    addRow(OpCmd, 1, `KL_LD_DIS, 4'b0100, 0, 0, 0);
    addRow(OpCmd, 0, `KL_FN_START, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 5, 10);
    addRow(OpCmd, 0, `KL_FN_STOP, 0, 0, 0, 0);
    addRow(OpPulse, 0, 0, 0, 0, 0, 4);
    addRow(OpRead, 0, 2, 0, 0, 0, 0);
    addRow(OpRead, 0, 3, 0, 0, 0, 0);

    limit = 5 + 50;
    foreach (rows[i]) begin
      limit += (rows[i].op == OpPulse) ? int'(rows[i].window) :
               (rows[i].op == OpRead) ? 2 : 1;
    end

    repeat (5) @(posedge CLK);
    #1;
    FPGA_RESET = 1'b0;
    foreach (rows[i]) begin
      case (rows[i].op)
        OpCmd:   runCmd(rows[i]);
        OpRead:  runRead(rows[i]);
        default: runPulses(rows[i]);
      endcase
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/klClkPkg.sv
logic/clkFuncDecode.sv
logic/clkConfigRegs.sv
logic/clkBurstCounter.sv
logic/clkRunControl.sv
logic/clkDiagRead.sv
logic/klClk.sv
tests/klClkTb.sv

// ==== Makefile ====
# Verilator lint, simulation and cleanup
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module klClk -f filelist.f

sim:
	verilator --binary --timing --assert --top-module klClkTb -f filelist.f -o klClkTb
	-./obj_dir/klClkTb > sim.log 2>&1
	cat sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
